//--- build.f
logic/yurut_pkg.sv
logic/uop_if.sv
logic/alu.sv
logic/decoder.sv
logic/execute.sv
logic/ex_top.sv
dv/ex_chk.sv
dv/tb_top.sv

//--- run.sh
#!/bin/sh
# Builds the execute slice testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_top \
    -f build.f \
    -o tb_top_sim

./obj_dir/tb_top_sim

//--- dv/tb_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_top import yurut_pkg::*; ();

    localparam int TAG_W        = 4;
    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 4;
    // Two cycles per instruction, three when a younger one follows.
    localparam int TEST_CYCLES  = RESET_CYCLES + 1 + 20 * 2 + 8 * 2 + 36 * 3 + 2 * 3 + 8 + 2 * 2;
    localparam int MARGIN       = 50;

    typedef struct packed {
        logic [XLEN-1:0] data;
        logic            we;
        logic            cf;
        logic            taken;
        logic            mis;
        logic [XLEN-1:0] rpc;
    } expect_t;

    logic             clk = 1'b0;
    logic             rstn;
    logic             in_valid;
    logic [31:0]      in_instr;
    logic [XLEN-1:0]  in_pc;
    logic             in_pred_taken;
    logic [XLEN-1:0]  in_rs1_data;
    logic [XLEN-1:0]  in_rs2_data;
    logic [TAG_W-1:0] in_tag;
    logic             stall;
    logic             redirect_valid;
    logic [XLEN-1:0]  redirect_pc;
    logic             bp_update;
    logic [XLEN-1:0]  bp_pc;
    logic             bp_taken;
    logic             bp_mispredict;
    logic             res_valid;
    logic [TAG_W-1:0] res_tag;
    logic [4:0]       res_rd;
    logic             res_we;
    logic [XLEN-1:0]  res_data;
    int unsigned      seed;

    ex_top #(
        .TAG_W (TAG_W)
    ) u_dut (
        .clk_i            (clk),
        .rstn_i           (rstn),
        .in_valid_i       (in_valid),
        .in_instr_i       (in_instr),
        .in_pc_i          (in_pc),
        .in_pred_taken_i  (in_pred_taken),
        .in_rs1_data_i    (in_rs1_data),
        .in_rs2_data_i    (in_rs2_data),
        .in_tag_i         (in_tag),
        .stall_i          (stall),
        .redirect_valid_o (redirect_valid),
        .redirect_pc_o    (redirect_pc),
        .bp_update_o      (bp_update),
        .bp_pc_o          (bp_pc),
        .bp_taken_o       (bp_taken),
        .bp_mispredict_o  (bp_mispredict),
        .res_valid_o      (res_valid),
        .res_tag_o        (res_tag),
        .res_rd_o         (res_rd),
        .res_we_o         (res_we),
        .res_data_o       (res_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abort_run();
        $display("Something failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(string test, string field, logic [31:0] exp,
                                   logic [31:0] act);
        $display("[ERROR] %s: %s expected %h, actual %h", test, field, exp, act);
        abort_run();
    endtask

    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd);
        enc_r = {f7, 5'd2, 5'd1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(logic [11:0] imm, logic [2:0] f3, logic [4:0] rd,
                                          logic [6:0] opc);
        enc_i = {imm, 5'd1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_b(logic [12:0] imm, logic [2:0] f3);
        enc_b = {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
        enc_j = {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    // One R-type word per ALU operation, ADD through SRA.
    function automatic logic [31:0] r_op(int k, logic [4:0] rd);
        case (k)
            0:       r_op = enc_r(7'h00, 3'd0, rd);
            1:       r_op = enc_r(7'h20, 3'd0, rd);
            2:       r_op = enc_r(7'h00, 3'd7, rd);
            3:       r_op = enc_r(7'h00, 3'd6, rd);
            4:       r_op = enc_r(7'h00, 3'd4, rd);
            5:       r_op = enc_r(7'h00, 3'd2, rd);
            6:       r_op = enc_r(7'h00, 3'd3, rd);
            7:       r_op = enc_r(7'h00, 3'd1, rd);
            8:       r_op = enc_r(7'h00, 3'd5, rd);
            default: r_op = enc_r(7'h20, 3'd5, rd);
        endcase
    endfunction

    function automatic logic [XLEN-1:0] ref_alu(logic [2:0] f3, logic alt,
                                                logic [XLEN-1:0] a, logic [XLEN-1:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            3'b000:  ref_alu = alt ? a - b : a + b;
            3'b001:  ref_alu = a << sh;
            3'b010:  ref_alu = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  ref_alu = (a < b) ? 32'd1 : 32'd0;
            3'b100:  ref_alu = a ^ b;
            3'b101:  ref_alu = (a >> sh) | ((alt && a[31]) ? ~(32'hFFFF_FFFF >> sh) : 32'd0);
            3'b110:  ref_alu = a | b;
            default: ref_alu = a & b;
        endcase
    endfunction

    // Expected behavior of one RV32I word, straight from the ISA rules.
    function automatic expect_t model(logic [31:0] ins, logic [XLEN-1:0] pc,
                                      logic [XLEN-1:0] rs1, logic [XLEN-1:0] rs2, logic pred);
        expect_t         e;
        logic [2:0]      f3;
        logic            wr;
        logic [XLEN-1:0] imm_i;
        logic [XLEN-1:0] imm_b;
        logic [XLEN-1:0] imm_j;
        logic [XLEN-1:0] tgt;
        e     = '0;
        wr    = 1'b0;
        tgt   = '0;
        f3    = ins[14:12];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        case (ins[6:0])
            7'b0110011: begin
                e.data = ref_alu(f3, ins[30], rs1, rs2);
                wr     = 1'b1;
            end
            7'b0010011: begin
                e.data = ref_alu(f3, ins[30] && (f3 == 3'b101), rs1, imm_i);
                wr     = 1'b1;
            end
            7'b0110111: begin
                e.data = {ins[31:12], 12'h000};
                wr     = 1'b1;
            end
            7'b1101111, 7'b1100111: begin
                e.data  = pc + 32'd4;
                wr      = 1'b1;
                e.cf    = 1'b1;
                e.taken = 1'b1;
                tgt     = ins[3] ? pc + imm_j : (rs1 + imm_i) & ~32'd1;
            end
            7'b1100011: begin
                e.cf = 1'b1;
                tgt  = pc + imm_b;
                case (f3)
                    3'b000:  e.taken = (rs1 == rs2);
                    3'b001:  e.taken = (rs1 != rs2);
                    3'b100:  e.taken = ($signed(rs1) < $signed(rs2));
                    3'b101:  e.taken = ($signed(rs1) >= $signed(rs2));
                    3'b110:  e.taken = (rs1 < rs2);
                    default: e.taken = (rs1 >= rs2);
                endcase
            end
            default: ;
        endcase
        e.we  = wr && (ins[11:7] != 5'd0);
        e.mis = e.cf && (e.taken != pred);
        e.rpc = e.taken ? tgt : pc + 32'd4;
        model = e;
    endfunction

    task automatic check_result(string name, logic exp_valid, logic [XLEN-1:0] exp_data,
                                logic [4:0] exp_rd, logic exp_we, logic [TAG_W-1:0] exp_tag);
        if (res_valid !== exp_valid) begin
            report_mismatch(name, "res_valid", 32'(exp_valid), 32'(res_valid));
        end else if (exp_valid) begin
            if (res_data !== exp_data) begin
                report_mismatch(name, "res_data", exp_data, res_data);
            end else if (res_rd !== exp_rd) begin
                report_mismatch(name, "res_rd", 32'(exp_rd), 32'(res_rd));
            end else if (res_we !== exp_we) begin
                report_mismatch(name, "res_we", 32'(exp_we), 32'(res_we));
            end else if (res_tag !== exp_tag) begin
                report_mismatch(name, "res_tag", 32'(exp_tag), 32'(res_tag));
            end
        end
    endtask

    task automatic check_branch(string name, logic exp_update, logic exp_taken,
                                logic exp_mis, logic [XLEN-1:0] exp_pc);
        if (bp_update !== exp_update) begin
            report_mismatch(name, "bp_update", 32'(exp_update), 32'(bp_update));
        end else if (bp_taken !== exp_taken) begin
            report_mismatch(name, "bp_taken", 32'(exp_taken), 32'(bp_taken));
        end else if (bp_mispredict !== exp_mis) begin
            report_mismatch(name, "bp_mispredict", 32'(exp_mis), 32'(bp_mispredict));
        end else if (exp_update && (bp_pc !== exp_pc)) begin
            report_mismatch(name, "bp_pc", exp_pc, bp_pc);
        end
    endtask

    task automatic check_redirect(string name, logic exp_valid, logic [XLEN-1:0] exp_pc);
        if (redirect_valid !== exp_valid) begin
            report_mismatch(name, "redirect_valid", 32'(exp_valid), 32'(redirect_valid));
        end else if (exp_valid && (redirect_pc !== exp_pc)) begin
            report_mismatch(name, "redirect_pc", exp_pc, redirect_pc);
        end
    endtask

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic drive(logic [31:0] ins, logic [XLEN-1:0] pc, logic pred,
                         logic [XLEN-1:0] rs1, logic [XLEN-1:0] rs2, logic [TAG_W-1:0] tag);
        in_valid      = 1'b1;
        in_instr      = ins;
        in_pc         = pc;
        in_pred_taken = pred;
        in_rs1_data   = rs1;
        in_rs2_data   = rs2;
        in_tag        = tag;
    endtask

    task automatic idle();
        in_valid = 1'b0;
    endtask

    // Issues one word, checks feedback then result; a younger ADDI can follow it.
    task automatic run_one(string name, logic [31:0] ins, logic [XLEN-1:0] pc,
                           logic [XLEN-1:0] rs1, logic [XLEN-1:0] rs2, logic pred,
                           logic [TAG_W-1:0] tag, logic follow);
        expect_t     e;
        expect_t     ey;
        logic [31:0] young;
        young = enc_i(12'h001, 3'd0, 5'd7, OPC_OP_IMM);
        e     = model(ins, pc, rs1, rs2, pred);
        ey    = model(young, pc + 32'd4, 32'h100, 32'd0, 1'b0);
        drive(ins, pc, pred, rs1, rs2, tag);
        tick();
        check_branch(name, e.cf, e.taken, e.mis, pc);
        check_redirect(name, e.mis, e.rpc);
        if (follow) begin
            drive(young, pc + 32'd4, 1'b0, 32'h100, 32'd0, ~tag);
        end else begin
            idle();
        end
        tick();
        check_result(name, 1'b1, e.data, ins[11:7], e.we, tag);
        if (follow) begin
            idle();
            tick();
            check_result(name, !e.mis, ey.data, 5'd7, ey.we, ~tag);   // Flushed on a redirect.
        end
    endtask

    task automatic test_reg_alu();
        logic [31:0] r;
        for (int i = 0; i < 20; i++) begin
            r = $urandom();
            run_one("test_reg_alu", r_op(i % 10, r[4:0]), 32'h1000 + 32'(i) * 32'd4,
                    $urandom(), $urandom(), 1'b0, TAG_W'(r >> 8), 1'b0);
        end
    endtask

    task automatic test_imm_lui();
        string n;
        n = "test_imm_lui";
        run_one(n, enc_i(12'hFF0, 3'd0, 5'd5, OPC_OP_IMM), 32'h1100, 32'd100, 0, 1'b0, 4'h1, 1'b0);
        run_one(n, enc_i(12'h005, 3'd2, 5'd6, OPC_OP_IMM), 32'h1104, -32'sd7, 0, 1'b0, 4'h2, 1'b0);
        run_one(n, enc_i(12'hF0F, 3'd4, 5'd7, OPC_OP_IMM), 32'h1108, 32'h1234_5678, 0, 1'b0,
                4'h3, 1'b0);
        run_one(n, enc_i(12'h004, 3'd1, 5'd8, OPC_OP_IMM), 32'h110C, 32'h8765_4321, 0, 1'b0,
                4'h4, 1'b0);
        run_one(n, enc_i(12'h008, 3'd5, 5'd9, OPC_OP_IMM), 32'h1110, 32'h8000_0F00, 0, 1'b0,
                4'h5, 1'b0);
        run_one(n, enc_i(12'h408, 3'd5, 5'd10, OPC_OP_IMM), 32'h1114, 32'h8000_0F00, 0, 1'b0,
                4'h6, 1'b0);   // SRAI on a negative value.
        run_one(n, {20'hABCDE, 5'd11, OPC_LUI}, 32'h1118, 0, 0, 1'b0, 4'h7, 1'b0);
        run_one(n, enc_i(12'h07F, 3'd0, 5'd0, OPC_OP_IMM), 32'h111C, 32'd1, 0, 1'b0, 4'h8, 1'b0);
    endtask

    task automatic test_branches();
        logic [2:0]      f3;
        logic [12:0]     off;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] pc;
        logic [31:0]     ins;
        expect_t         e;
        for (int k = 0; k < 6; k++) begin
            f3 = (k < 2) ? 3'(k) : 3'(k + 2);
            for (int p = 0; p < 3; p++) begin
                a   = (p == 0) ? 32'd5 : ((p == 1) ? 32'hFFFF_FFFD : 32'd4);
                b   = (p == 0) ? 32'd5 : ((p == 1) ? 32'd4 : 32'hFFFF_FFFD);
                off = (p == 1) ? 13'h1FC0 : 13'h0040;
                pc  = 32'h2000 + 32'(k) * 32'h100 + 32'(p) * 32'h10;
                ins = enc_b(off, f3);
                e   = model(ins, pc, a, b, 1'b0);
                run_one("test_branches", ins, pc, a, b, e.taken, TAG_W'(k), 1'b1);
                run_one("test_branches", ins, pc, a, b, ~e.taken, TAG_W'(k), 1'b1);
            end
        end
    endtask

    task automatic test_jumps();
        run_one("test_jumps", enc_j(21'h000080, 5'd1), 32'h3000, 0, 0, 1'b0, 4'hA, 1'b1);
        // Odd sum, so the low target bit must be cleared.
        run_one("test_jumps", enc_i(12'h021, 3'd0, 5'd3, OPC_JALR), 32'h3100, 32'h4000, 0,
                1'b0, 4'hB, 1'b1);
    endtask

    task automatic test_stall();
        string       n;
        logic [31:0] addi;
        logic [31:0] beq;
        expect_t     ea;
        expect_t     eb;
        n    = "test_stall";
        addi = enc_i(12'h010, 3'd0, 5'd4, OPC_OP_IMM);
        beq  = enc_b(13'h0080, 3'd0);
        ea   = model(addi, 32'h5000, 32'd3, 0, 1'b0);
        eb   = model(beq, 32'h5004, 32'd9, 32'd9, 1'b0);
        drive(addi, 32'h5000, 1'b0, 32'd3, 32'd0, 4'hC);
        tick();
        drive(beq, 32'h5004, 1'b0, 32'd9, 32'd9, 4'hD);
        tick();
        check_result(n, 1'b1, ea.data, 5'd4, ea.we, 4'hC);
        check_redirect(n, 1'b1, eb.rpc);
        idle();
        stall = 1'b1;
        for (int i = 0; i < 3; i++) begin
            tick();
            check_result(n, 1'b1, ea.data, 5'd4, ea.we, 4'hC);
            check_branch(n, 1'b0, 1'b0, 1'b0, 32'd0);
            check_redirect(n, 1'b0, 32'd0);
        end
        stall = 1'b0;
        #1;
        check_branch(n, 1'b1, eb.taken, eb.mis, 32'h5004);
        check_redirect(n, 1'b1, eb.rpc);
        tick();
        check_result(n, 1'b1, eb.data, beq[11:7], eb.we, 4'hD);
        check_redirect(n, 1'b0, 32'd0);
        tick();
        check_result(n, 1'b0, 32'd0, 5'd0, 1'b0, 4'h0);
    endtask

    task automatic test_unknown();
        run_one("test_unknown", {25'h0000_0A5, 7'b1111011}, 32'h6000, 32'd1, 32'd2, 1'b0,
                4'hE, 1'b0);
        run_one("test_unknown", enc_i(12'h004, 3'd2, 5'd12, 7'b0000011), 32'h6004, 32'd1,
                32'd2, 1'b0, 4'hF, 1'b0);   // Loads are outside the slice.
    endtask

    initial begin
        seed          = $urandom(76);
        rstn          = 1'b0;
        stall         = 1'b0;
        in_valid      = 1'b0;
        in_instr      = '0;
        in_pc         = '0;
        in_pred_taken = 1'b0;
        in_rs1_data   = '0;
        in_rs2_data   = '0;
        in_tag        = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rstn = 1'b1;
        tick();
        check_result("reset", 1'b0, 32'd0, 5'd0, 1'b0, 4'h0);
        check_branch("reset", 1'b0, 1'b0, 1'b0, 32'd0);
        check_redirect("reset", 1'b0, 32'd0);
        test_reg_alu();
        test_imm_lui();
        test_branches();
        test_jumps();
        test_stall();
        test_unknown();
        $display("Everything OK");
        $finish;
    end

    initial begin
        #(CLK_PERIOD * (TEST_CYCLES + MARGIN));
        $display("Watchdog: the tests did not finish within %0d cycles", TEST_CYCLES + MARGIN);
        abort_run();
    end

endmodule

`default_nettype wire

//--- dv/ex_chk.sv
`timescale 1ns/1ns
`default_nettype none

module ex_chk import yurut_pkg::*; (
    input logic            clk_i,
    input logic            rstn_i,
    input logic            stall_i,
    input logic            redirect_valid_o,
    input logic            bp_update_o,
    input logic            bp_mispredict_o,
    input logic            res_valid_o,
    input logic            res_we_o,
    input logic [4:0]      res_rd_o,
    input logic [XLEN-1:0] res_data_o
);

    // The result register freezes while the slice is stalled.
    a_stall_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        stall_i |=> $stable(res_valid_o) && $stable(res_we_o) &&
                    $stable(res_rd_o) && $stable(res_data_o))
        else $error("result outputs moved during a stall");

    a_stall_quiet: assert property (@(posedge clk_i) disable iff (!rstn_i)
        stall_i |-> !redirect_valid_o && !bp_update_o)
        else $error("redirect or branch update raised during a stall");

    a_redirect_mispredict: assert property (@(posedge clk_i) disable iff (!rstn_i)
        redirect_valid_o |-> bp_mispredict_o)
        else $error("redirect without a misprediction");

    a_no_x0_write: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(res_we_o && (res_rd_o == 5'd0)))
        else $error("write enable raised for x0");

    a_reset_quiet: assert property (@(posedge clk_i)
        $rose(rstn_i) |-> !res_valid_o && !redirect_valid_o && !bp_update_o)
        else $error("output valid high right after reset");

endmodule

bind ex_top ex_chk u_chk (.*);

`default_nettype wire

//--- logic/ex_top.sv
`timescale 1ns/1ns
`default_nettype none

module ex_top import yurut_pkg::*; #(
    parameter int TAG_W = 4
) (
    input  logic             clk_i,
    input  logic             rstn_i,

    input  logic             in_valid_i,
    input  logic [31:0]      in_instr_i,
    input  logic [XLEN-1:0]  in_pc_i,
    input  logic             in_pred_taken_i,
    input  logic [XLEN-1:0]  in_rs1_data_i,
    input  logic [XLEN-1:0]  in_rs2_data_i,
    input  logic [TAG_W-1:0] in_tag_i,
    input  logic             stall_i,

    output logic             redirect_valid_o,
    output logic [XLEN-1:0]  redirect_pc_o,

    output logic             bp_update_o,
    output logic [XLEN-1:0]  bp_pc_o,
    output logic             bp_taken_o,
    output logic             bp_mispredict_o,

    output logic             res_valid_o,
    output logic [TAG_W-1:0] res_tag_o,
    output logic [4:0]       res_rd_o,
    output logic             res_we_o,
    output logic [XLEN-1:0]  res_data_o
);

    uop_if u_uop_if ();

    decoder #(
        .TAG_W (TAG_W)
    ) u_dec (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .in_valid_i      (in_valid_i),
        .in_instr_i      (in_instr_i),
        .in_pc_i         (in_pc_i),
        .in_pred_taken_i (in_pred_taken_i),
        .in_rs1_data_i   (in_rs1_data_i),
        .in_rs2_data_i   (in_rs2_data_i),
        .in_tag_i        (in_tag_i),
        .out_if          (u_uop_if.dec_mp)
    );

    execute #(
        .TAG_W (TAG_W)
    ) u_ex (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .stall_i          (stall_i),
        .in_if            (u_uop_if.ex_mp),
        .redirect_valid_o (redirect_valid_o),
        .redirect_pc_o    (redirect_pc_o),
        .bp_update_o      (bp_update_o),
        .bp_pc_o          (bp_pc_o),
        .bp_taken_o       (bp_taken_o),
        .bp_mispredict_o  (bp_mispredict_o),
        .res_valid_o      (res_valid_o),
        .res_tag_o        (res_tag_o),
        .res_rd_o         (res_rd_o),
        .res_we_o         (res_we_o),
        .res_data_o       (res_data_o)
    );

endmodule

`default_nettype wire

//--- logic/execute.sv
`timescale 1ns/1ns
`default_nettype none

module execute import yurut_pkg::*; #(
    parameter int TAG_W = 4
) (
    input  logic             clk_i,
    input  logic             rstn_i,
    input  logic             stall_i,

    uop_if.ex_mp             in_if,

    output logic             redirect_valid_o,
    output logic [XLEN-1:0]  redirect_pc_o,

    output logic             bp_update_o,
    output logic [XLEN-1:0]  bp_pc_o,
    output logic             bp_taken_o,
    output logic             bp_mispredict_o,

    output logic             res_valid_o,
    output logic [TAG_W-1:0] res_tag_o,
    output logic [4:0]       res_rd_o,
    output logic             res_we_o,
    output logic [XLEN-1:0]  res_data_o
);

    uop_t            uop;
    logic            active;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_res;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] target;
    logic            cmp_eq;
    logic            cmp_lt;
    logic            cmp_ltu;
    logic            taken;
    logic            is_cf;
    logic [XLEN-1:0] wb_data;
    logic            wb_en;

    logic             res_valid_q;
    logic             res_we_q;
    logic [TAG_W-1:0] res_tag_q;
    logic [4:0]       res_rd_q;
    logic [XLEN-1:0]  res_data_q;

    function automatic logic [XLEN-1:0] pick(opnd_sel_e sel, uop_t u);
        case (sel)
            OP_RS1:  pick = u.rs1_val;
            OP_RS2:  pick = u.rs2_val;
            OP_IMM:  pick = u.imm;
            OP_PC:   pick = u.pc;
            default: pick = '0;
        endcase
    endfunction

    assign uop    = in_if.uop;
    assign active = in_if.valid & ~stall_i;

    assign op_a     = pick(uop.op1_sel, uop);
    assign op_b     = pick(uop.op2_sel, uop);
    assign pc_plus4 = uop.pc + XLEN'(4);

    alu u_alu (
        .op_i     (uop.alu_op),
        .a_i      (op_a),
        .b_i      (op_b),
        .result_o (alu_res),
        .eq_o     (),
        .lt_o     (),
        .ltu_o    ()
    );

    // Branch compare runs beside the target adder.
    alu u_cmp (
        .op_i     (ALU_SUB),
        .a_i      (uop.rs1_val),
        .b_i      (uop.rs2_val),
        .result_o (),
        .eq_o     (cmp_eq),
        .lt_o     (cmp_lt),
        .ltu_o    (cmp_ltu)
    );

    assign target = {alu_res[XLEN-1:1], alu_res[0] & (uop.br_kind != BR_JALR)};

    always_comb begin
        case (uop.br_kind)
            BR_BEQ:  taken = cmp_eq;
            BR_BNE:  taken = ~cmp_eq;
            BR_BLT:  taken = cmp_lt;
            BR_BGE:  taken = ~cmp_lt;
            BR_BLTU: taken = cmp_ltu;
            BR_BGEU: taken = ~cmp_ltu;
            BR_JAL:  taken = 1'b1;
            BR_JALR: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign is_cf = (uop.br_kind != BR_NONE);

    assign bp_update_o      = active & is_cf;
    assign bp_pc_o          = uop.pc;
    assign bp_taken_o       = bp_update_o & taken;
    assign bp_mispredict_o  = bp_update_o & (taken != uop.pred_taken);
    assign redirect_valid_o = bp_mispredict_o;
    assign redirect_pc_o    = taken ? target : pc_plus4;

    assign in_if.stall = stall_i;
    assign in_if.flush = redirect_valid_o;

    always_comb begin
        case (uop.wb_sel)
            WB_ALU:  wb_data = alu_res;
            WB_LINK: wb_data = pc_plus4;
            default: wb_data = '0;
        endcase
    end

    assign wb_en = in_if.valid & (uop.wb_sel != WB_NONE) & (uop.rd != 5'd0);

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            res_valid_q <= 1'b0;
            res_we_q    <= 1'b0;
        end else if (!stall_i) begin
            res_valid_q <= in_if.valid;
            res_we_q    <= wb_en;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            res_tag_q  <= uop.tag[TAG_W-1:0];
            res_rd_q   <= uop.rd;
            res_data_q <= wb_data;
        end
    end

    assign res_valid_o = res_valid_q;
    assign res_we_o    = res_we_q;
    assign res_tag_o   = res_tag_q;
    assign res_rd_o    = res_rd_q;
    assign res_data_o  = res_data_q;

endmodule

`default_nettype wire

//--- logic/decoder.sv
`timescale 1ns/1ns
`default_nettype none

module decoder import yurut_pkg::*; #(
    parameter int TAG_W = 4
) (
    input  logic             clk_i,
    input  logic             rstn_i,

    input  logic             in_valid_i,
    input  logic [31:0]      in_instr_i,
    input  logic [XLEN-1:0]  in_pc_i,
    input  logic             in_pred_taken_i,
    input  logic [XLEN-1:0]  in_rs1_data_i,
    input  logic [XLEN-1:0]  in_rs2_data_i,
    input  logic [TAG_W-1:0] in_tag_i,

    uop_if.dec_mp            out_if
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic            alt_op;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_j;

    uop_t uop_d;
    uop_t uop_q;
    logic valid_q;

    function automatic alu_op_e alu_op_from(logic [2:0] f3, logic alt);
        case (f3)
            3'b000:  alu_op_from = alt ? ALU_SUB : ALU_ADD;
            3'b001:  alu_op_from = ALU_SLL;
            3'b010:  alu_op_from = ALU_SLT;
            3'b011:  alu_op_from = ALU_SLTU;
            3'b100:  alu_op_from = ALU_XOR;
            3'b101:  alu_op_from = alt ? ALU_SRA : ALU_SRL;
            3'b110:  alu_op_from = ALU_OR;
            default: alu_op_from = ALU_AND;
        endcase
    endfunction

    assign opcode = in_instr_i[6:0];
    assign funct3 = in_instr_i[14:12];

    // funct7[5] selects SUB/SRA; ADDI has no SUB form.
    assign alt_op = in_instr_i[30] & ((opcode == OPC_OP) | (funct3 == 3'b101));

    assign imm_i = {{20{in_instr_i[31]}}, in_instr_i[31:20]};
    assign imm_u = {in_instr_i[31:12], 12'b0};
    assign imm_b = {{19{in_instr_i[31]}}, in_instr_i[31], in_instr_i[7],
                    in_instr_i[30:25], in_instr_i[11:8], 1'b0};
    assign imm_j = {{11{in_instr_i[31]}}, in_instr_i[31], in_instr_i[19:12],
                    in_instr_i[20], in_instr_i[30:21], 1'b0};

    always_comb begin
        uop_d            = '0;
        uop_d.pc         = in_pc_i;
        uop_d.tag[TAG_W-1:0] = in_tag_i;
        uop_d.pred_taken = in_pred_taken_i;
        uop_d.rs1_val    = in_rs1_data_i;
        uop_d.rs2_val    = in_rs2_data_i;
        uop_d.rd         = in_instr_i[11:7];
        uop_d.alu_op     = ALU_ADD;
        uop_d.op1_sel    = OP_ZERO;
        uop_d.op2_sel    = OP_ZERO;
        uop_d.wb_sel     = WB_NONE;     // Unknown opcodes pass as harmless bubbles.
        uop_d.br_kind    = BR_NONE;

        case (opcode)
            OPC_OP: begin
                uop_d.alu_op  = alu_op_from(funct3, alt_op);
                uop_d.op1_sel = OP_RS1;
                uop_d.op2_sel = OP_RS2;
                uop_d.wb_sel  = WB_ALU;
            end
            OPC_OP_IMM: begin
                uop_d.alu_op  = alu_op_from(funct3, alt_op);
                uop_d.op1_sel = OP_RS1;
                uop_d.op2_sel = OP_IMM;
                uop_d.imm     = imm_i;
                uop_d.wb_sel  = WB_ALU;
            end
            OPC_LUI: begin
                uop_d.op2_sel = OP_IMM;
                uop_d.imm     = imm_u;
                uop_d.wb_sel  = WB_ALU;
            end
            OPC_JAL: begin
                uop_d.op1_sel = OP_PC;
                uop_d.op2_sel = OP_IMM;
                uop_d.imm     = imm_j;
                uop_d.wb_sel  = WB_LINK;
                uop_d.br_kind = BR_JAL;
            end
            OPC_JALR: begin
                uop_d.op1_sel = OP_RS1;
                uop_d.op2_sel = OP_IMM;
                uop_d.imm     = imm_i;
                uop_d.wb_sel  = WB_LINK;
                uop_d.br_kind = BR_JALR;
            end
            OPC_BRANCH: begin
                uop_d.op1_sel = OP_PC;      // Main ALU forms the target.
                uop_d.op2_sel = OP_IMM;
                uop_d.imm     = imm_b;
                case (funct3)
                    3'b000:  uop_d.br_kind = BR_BEQ;
                    3'b001:  uop_d.br_kind = BR_BNE;
                    3'b100:  uop_d.br_kind = BR_BLT;
                    3'b101:  uop_d.br_kind = BR_BGE;
                    3'b110:  uop_d.br_kind = BR_BLTU;
                    3'b111:  uop_d.br_kind = BR_BGEU;
                    default: uop_d.br_kind = BR_NONE;
                endcase
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            valid_q <= 1'b0;
        end else if (!out_if.stall) begin
            valid_q <= in_valid_i & ~out_if.flush;   // Flush drops the incoming word.
        end
    end

    always_ff @(posedge clk_i) begin
        if (!out_if.stall) begin
            uop_q <= uop_d;
        end
    end

    assign out_if.valid = valid_q;
    assign out_if.uop   = uop_q;

endmodule

`default_nettype wire

//--- logic/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu import yurut_pkg::*; (
    input  alu_op_e         op_i,
    input  logic [XLEN-1:0] a_i,
    input  logic [XLEN-1:0] b_i,
    output logic [XLEN-1:0] result_o,
    output logic            eq_o,
    output logic            lt_o,
    output logic            ltu_o
);

    logic [4:0] shamt;

    assign shamt = b_i[4:0];

    assign eq_o  = (a_i == b_i);
    assign lt_o  = ($signed(a_i) < $signed(b_i));
    assign ltu_o = (a_i < b_i);

    always_comb begin
        case (op_i)
            ALU_ADD: begin
                result_o = a_i + b_i;
            end
            ALU_SUB: begin
                result_o = a_i - b_i;
            end
            ALU_AND: begin
                result_o = a_i & b_i;
            end
            ALU_OR: begin
                result_o = a_i | b_i;
            end
            ALU_XOR: begin
                result_o = a_i ^ b_i;
            end
            ALU_SLT: begin
                result_o = {{(XLEN-1){1'b0}}, lt_o};
            end
            ALU_SLTU: begin
                result_o = {{(XLEN-1){1'b0}}, ltu_o};
            end
            ALU_SLL: begin
                result_o = a_i << shamt;
            end
            ALU_SRL: begin
                result_o = a_i >> shamt;
            end
            ALU_SRA: begin
                result_o = $unsigned($signed(a_i) >>> shamt);   // Keeps the sign bit.
            end
            default: begin
                result_o = a_i + b_i;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- logic/uop_if.sv
`timescale 1ns/1ns
`default_nettype none

interface uop_if import yurut_pkg::*; ();

    logic valid;
    uop_t uop;
    logic stall;
    logic flush;    // Kills the micro-op younger than a mispredicted branch.

    modport dec_mp (
        output valid,
        output uop,
        input  stall,
        input  flush
    );

    modport ex_mp (
        input  valid,
        input  uop,
        output stall,
        output flush
    );

endinterface

`default_nettype wire

//--- logic/yurut_pkg.sv
`default_nettype none

package yurut_pkg;

    localparam int XLEN      = 32;
    localparam int TAG_MAX_W = 8;

    // RV32I major opcodes handled by the slice.
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_op_e;

    typedef enum logic [2:0] {
        OP_ZERO,
        OP_RS1,
        OP_RS2,
        OP_IMM,
        OP_PC
    } opnd_sel_e;

    typedef enum logic [1:0] {
        WB_NONE,
        WB_ALU,
        WB_LINK     // pc + 4.
    } wb_sel_e;

    typedef enum logic [3:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_BLTU,
        BR_BGEU,
        BR_JAL,
        BR_JALR
    } br_kind_e;

    typedef struct packed {
        logic [XLEN-1:0]      pc;
        logic [TAG_MAX_W-1:0] tag;          // Upper bits unused when TAG_W is smaller.
        logic                 pred_taken;
        logic [XLEN-1:0]      rs1_val;
        logic [XLEN-1:0]      rs2_val;
        logic [XLEN-1:0]      imm;          // Already sign extended.
        logic [4:0]           rd;
        alu_op_e              alu_op;
        opnd_sel_e            op1_sel;
        opnd_sel_e            op2_sel;
        wb_sel_e              wb_sel;
        br_kind_e             br_kind;
    } uop_t;

endpackage

`default_nettype wire
